// File: hdl/i2c_apb_regs.sv
`default_nettype none

module i2c_apb_regs import i2c_pkg::*; (
	input  wire                 Clk,
	input  wire                 Rst_n,
	// apb slave
	input  wire apb_addr_t      paddr_i,
	input  wire                 psel_i,
	input  wire                 penable_i,
	input  wire                 pwrite_i,
	input  wire apb_data_t      pwdata_i,
	output apb_data_t           prdata_o,
	output logic                pready_o,
	output logic                pslverr_o,
	// command fifo
	output logic                push_o,
	output i2c_cmd_entry_t      push_data_o,
	input  wire                 full_i,
	input  wire fifo_cnt_t      level_i,
	input  wire                 empty_i,
	// bit engine
	input  wire                 engine_busy_i,
	input  wire                 trans_done_i,
	input  wire i2c_data_t      rx_data_i,
	input  wire                 ack_i,
	output scl_div_t            scl_div_o
);

	logic      apb_access;  // access phase of a transfer
	logic      apb_wr;
	logic      addr_hit;    // one of the four registers
	logic      ro_wr;       // write to status or rxdata
	logic      full_wr;     // command write with no room
	logic      busy;
	scl_div_t  scl_div_q;
	i2c_data_t rx_data_q;
	logic      ack_q;       // 1 = last ack was a nack
	apb_data_t status_word;

	assign apb_access = psel_i & penable_i;
	assign apb_wr     = apb_access & pwrite_i;

	always_comb begin
		case (paddr_i)
			REG_CTRL, REG_CMD, REG_STATUS, REG_RXDATA: addr_hit = 1'b1;
			default: addr_hit = 1'b0;
		endcase
	end

	assign ro_wr   = apb_wr & ((paddr_i == REG_STATUS) | (paddr_i == REG_RXDATA));
	assign full_wr = apb_wr & (paddr_i == REG_CMD) & full_i; // command is dropped

	assign pready_o  = 1'b1; // no wait states
	assign pslverr_o = apb_access & (~addr_hit | ro_wr | full_wr);

	// push in the access cycle, only with room left
	assign push_o              = apb_wr & (paddr_i == REG_CMD) & ~full_i;
	assign push_data_o.flags   = pwdata_i[13:8];
	assign push_data_o.tx_data = pwdata_i[7:0];

	// divider
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			scl_div_q <= SCL_DIV_RST;
		end else if (apb_wr && (paddr_i == REG_CTRL)) begin
			scl_div_q <= pwdata_i[19:0];
		end
	end

	assign scl_div_o = scl_div_q;

	// last result of the engine, taken on each done pulse
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			rx_data_q <= '0;
			ack_q     <= 1'b0;
		end else if (trans_done_i) begin
			rx_data_q <= rx_data_i;
			ack_q     <= ack_i;
		end
	end

	// queued work or a command on the wire
	assign busy = ~empty_i | engine_busy_i;

	always_comb begin
		status_word      = '0;
		status_word[0]   = busy;
		status_word[1]   = full_i;
		status_word[2]   = ack_q;
		status_word[6:4] = level_i; // fill level
	end

	// read mux, straight from the registers
	always_comb begin
		case (paddr_i)
			REG_CTRL:   prdata_o = {12'd0, scl_div_q};
			REG_STATUS: prdata_o = status_word;
			REG_RXDATA: prdata_o = {24'd0, rx_data_q};
			default:    prdata_o = '0; // cmd reads as zero
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/i2c_bit_shift.sv
`default_nettype none

module i2c_bit_shift import i2c_pkg::*; (
	input  wire                 Clk,
	input  wire                 Rst_n,
	// command fifo
	output logic                pop_o,
	input  wire i2c_cmd_entry_t pop_data_i,
	input  wire                 empty_i,
	// control and results
	input  wire scl_div_t       scl_div_i,
	output i2c_data_t           rx_data_o,
	output logic                ack_o,
	output logic                trans_done_o,
	output logic                busy_o,
	// i2c pins
	output logic                scl_o,
	output logic                sda_oe_o,   // 1 pulls sda low
	input  wire                 sda_i
);

	bit_state_t     state;
	bit_state_t     launch_state; // first state of the head command
	bit_state_t     post_sta;     // state after start, latched command
	i2c_cmd_entry_t cmd_q;
	scl_div_t       div_cnt;
	logic           quarter;      // end of a quarter-bit
	logic [4:0]     phase;        // quarter index in the current part
	logic [4:0]     phase_last;
	logic           phase_end;
	logic           scl_q;
	logic           sda_low_q;
	logic           done_q;
	logic           ack_q;        // 1 = nack seen
	i2c_data_t      rx_shift;

	// part that follows a start, or the first part without one
	function automatic bit_state_t byte_state(input i2c_cmd_t f);
		bit_state_t s;
		if ((f & CMD_WR) != '0) begin
			s = ST_WR_DATA; // write wins over read
		end else if ((f & CMD_RD) != '0) begin
			s = ST_RD_DATA;
		end else if ((f & CMD_STO) != '0) begin
			s = ST_GEN_STO;
		end else begin
			s = ST_IDLE;
		end
		return s;
	endfunction

	assign launch_state = ((pop_data_i.flags & CMD_STA) != '0) ? ST_GEN_STA :
		byte_state(pop_data_i.flags);
	assign post_sta = byte_state(cmd_q.flags);

	// take the head while idle
	assign pop_o = (state == ST_IDLE) & ~empty_i;

	always_ff @(posedge Clk) begin
		if (pop_o) begin
			cmd_q <= pop_data_i;
		end
	end

	// quarter-bit divider, scl_div_i + 1 clocks per quarter
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			div_cnt <= '0;
		end else if ((state == ST_IDLE) || quarter) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign quarter = (state != ST_IDLE) && (div_cnt >= scl_div_i); // >= in case div shrinks

	// bytes take 32 quarters, the rest take 4
	assign phase_last = ((state == ST_WR_DATA) || (state == ST_RD_DATA)) ? 5'd31 : 5'd3;
	assign phase_end  = quarter && (phase == phase_last);

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			phase <= '0;
		end else if (phase_end) begin
			phase <= '0;
		end else if (quarter) begin
			phase <= phase + 1'b1;
		end
	end

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state     <= ST_IDLE;
			scl_q     <= 1'b1;
			sda_low_q <= 1'b0;
			done_q    <= 1'b0;
			ack_q     <= 1'b0;
			rx_shift  <= '0;
		end else begin
			done_q <= 1'b0; // pulse, set below
			case (state)
				ST_IDLE: begin
					sda_low_q <= 1'b0; // release between commands
					if (pop_o) begin
						state  <= launch_state;
						done_q <= (launch_state == ST_IDLE); // command with no flags
					end
				end
				ST_GEN_STA: begin
					if (quarter) begin
						case (phase[1:0])
							2'd0: begin
								scl_q     <= 1'b1; // both lines high first
								sda_low_q <= 1'b0;
							end
							2'd1:    sda_low_q <= 1'b1; // sda falls, scl high
							2'd2:    scl_q <= 1'b0;
							default: scl_q <= 1'b0; // hold low for data setup
						endcase
						if (phase_end) begin
							state  <= post_sta;
							done_q <= (post_sta == ST_IDLE);
						end
					end
				end
				ST_WR_DATA: begin
					if (quarter) begin
						case (phase[1:0])
							2'd0:    sda_low_q <= ~cmd_q.tx_data[3'd7 - phase[4:2]]; // msb first
							2'd1:    scl_q <= 1'b1;
							2'd2:    scl_q <= 1'b1;
							default: scl_q <= 1'b0;
						endcase
						if (phase_end) state <= ST_CHECK_ACK;
					end
				end
				ST_RD_DATA: begin
					if (quarter) begin
						case (phase[1:0])
							2'd0: begin
								scl_q     <= 1'b0;
								sda_low_q <= 1'b0; // slave drives the byte
							end
							2'd1:    scl_q <= 1'b1;
							2'd2:    rx_shift <= {rx_shift[6:0], sda_i}; // mid scl high
							default: scl_q <= 1'b0;
						endcase
						if (phase_end) state <= ST_GEN_ACK;
					end
				end
				ST_CHECK_ACK: begin
					if (quarter) begin
						case (phase[1:0])
							2'd0: begin
								scl_q     <= 1'b0;
								sda_low_q <= 1'b0; // line belongs to the slave
							end
							2'd1:    scl_q <= 1'b1;
							2'd2:    ack_q <= sda_i; // high means nack
							default: scl_q <= 1'b0;
						endcase
						if (phase_end) begin
							if ((cmd_q.flags & CMD_STO) != '0) begin
								state <= ST_GEN_STO;
							end else begin
								state  <= ST_IDLE;
								done_q <= 1'b1;
							end
						end
					end
				end
				ST_GEN_ACK: begin
					if (quarter) begin
						case (phase[1:0])
							2'd0: begin
								scl_q     <= 1'b0;
								// nack leaves sda released, even with ack set
								sda_low_q <= (|(cmd_q.flags & CMD_ACK)) &
									~(|(cmd_q.flags & CMD_NACK));
							end
							2'd1:    scl_q <= 1'b1;
							2'd2:    scl_q <= 1'b1;
							default: scl_q <= 1'b0;
						endcase
						if (phase_end) begin
							if ((cmd_q.flags & CMD_STO) != '0) begin
								state <= ST_GEN_STO;
							end else begin
								state  <= ST_IDLE;
								done_q <= 1'b1;
							end
						end
					end
				end
				ST_GEN_STO: begin
					if (quarter) begin
						case (phase[1:0])
							2'd0: begin
								scl_q     <= 1'b0;
								sda_low_q <= 1'b1; // sda low before scl rises
							end
							2'd1:    scl_q <= 1'b1;
							2'd2:    sda_low_q <= 1'b0; // sda rises under high scl
							default: scl_q <= 1'b1; // bus idle
						endcase
						if (phase_end) begin
							state  <= ST_IDLE;
							done_q <= 1'b1;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	assign scl_o        = scl_q;
	assign sda_oe_o     = sda_low_q;
	assign rx_data_o    = rx_shift;
	assign ack_o        = ack_q;
	assign trans_done_o = done_q;
	// busy until the result has been handed over
	assign busy_o       = (state != ST_IDLE) | done_q;

endmodule

`default_nettype wire

// File: hdl/i2c_cmd_fifo.sv
`default_nettype none

module i2c_cmd_fifo import i2c_pkg::*; (
	input  wire                 Clk,
	input  wire                 Rst_n,
	input  wire                 push_i,
	input  wire i2c_cmd_entry_t push_data_i,
	input  wire                 pop_i,
	output i2c_cmd_entry_t      pop_data_o,
	output logic                full_o,
	output logic                empty_o,
	output fifo_cnt_t           level_o
);

	i2c_cmd_entry_t        mem [FIFO_DEPTH]; // circular storage
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	fifo_cnt_t             count_q;
	logic                  do_push;
	logic                  do_pop;

	assign full_o  = (count_q == fifo_cnt_t'(FIFO_DEPTH));
	assign empty_o = (count_q == '0);
	assign level_o = count_q;

	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	// head entry, visible before the pop
	assign pop_data_o = mem[rd_ptr];

	always_ff @(posedge Clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	// pointers wrap on their own width
	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			count_q <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q; // none, or both at once
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/i2c_master_top.sv
`default_nettype none

module i2c_master_top import i2c_pkg::*; (
	input  wire            Clk,
	input  wire            Rst_n,
	// apb slave port
	input  wire apb_addr_t paddr_i,
	input  wire            psel_i,
	input  wire            penable_i,
	input  wire            pwrite_i,
	input  wire apb_data_t pwdata_i,
	output apb_data_t      prdata_o,
	output logic           pready_o,
	output logic           pslverr_o,
	// i2c, sda split for an external wired-and
	output logic           scl_o,
	output logic           sda_oe_o,
	input  wire            sda_i
);

	i2c_cmd_entry_t push_data;
	i2c_cmd_entry_t pop_data;  // fifo head
	logic           push;
	logic           pop;
	logic           full;
	logic           empty;
	fifo_cnt_t      level;
	logic           engine_busy;
	logic           trans_done;
	i2c_data_t      rx_data;
	logic           ack;
	scl_div_t       scl_div;

	// producer: apb registers
	i2c_apb_regs u_regs (
		.Clk           (Clk),
		.Rst_n         (Rst_n),
		.paddr_i       (paddr_i),
		.psel_i        (psel_i),
		.penable_i     (penable_i),
		.pwrite_i      (pwrite_i),
		.pwdata_i      (pwdata_i),
		.prdata_o      (prdata_o),
		.pready_o      (pready_o),
		.pslverr_o     (pslverr_o),
		.push_o        (push),
		.push_data_o   (push_data),
		.full_i        (full),
		.level_i       (level),
		.empty_i       (empty),
		.engine_busy_i (engine_busy),
		.trans_done_i  (trans_done),
		.rx_data_i     (rx_data),
		.ack_i         (ack),
		.scl_div_o     (scl_div)
	);

	i2c_cmd_fifo u_fifo (
		.Clk         (Clk),
		.Rst_n       (Rst_n),
		.push_i      (push),
		.push_data_i (push_data),
		.pop_i       (pop),
		.pop_data_o  (pop_data),
		.full_o      (full),
		.empty_o     (empty),
		.level_o     (level)
	);

	// consumer: bit engine on the pins
	i2c_bit_shift u_engine (
		.Clk          (Clk),
		.Rst_n        (Rst_n),
		.pop_o        (pop),
		.pop_data_i   (pop_data),
		.empty_i      (empty),
		.scl_div_i    (scl_div),
		.rx_data_o    (rx_data),
		.ack_o        (ack),
		.trans_done_o (trans_done),
		.busy_o       (engine_busy),
		.scl_o        (scl_o),
		.sda_oe_o     (sda_oe_o),
		.sda_i        (sda_i)
	);

endmodule

`default_nettype wire

// File: hdl/i2c_pkg.sv
`default_nettype none

package i2c_pkg;

	// apb and fifo sizing
	localparam int APB_ADDR_W = 8;
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2; // log2 of FIFO_DEPTH

	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [31:0]           apb_data_t;
	typedef logic [7:0]            i2c_data_t;  // one byte on the wire
	typedef logic [19:0]           scl_div_t;   // quarter-bit count limit
	typedef logic [FIFO_PTR_W:0]   fifo_cnt_t;  // 0 .. FIFO_DEPTH
	typedef logic [5:0]            i2c_cmd_t;   // one-hot command flags

	// register map
	localparam apb_addr_t REG_CTRL   = 8'h00; // divider
	localparam apb_addr_t REG_CMD    = 8'h04; // write pushes a command
	localparam apb_addr_t REG_STATUS = 8'h08; // read only
	localparam apb_addr_t REG_RXDATA = 8'h0C; // read only

	localparam scl_div_t SCL_DIV_RST = 20'd24; // ctrl value after reset

	// command flags, may be combined
	localparam i2c_cmd_t CMD_WR   = 6'b000001; // write byte
	localparam i2c_cmd_t CMD_STA  = 6'b000010; // start first
	localparam i2c_cmd_t CMD_RD   = 6'b000100; // read byte
	localparam i2c_cmd_t CMD_STO  = 6'b001000; // stop last
	localparam i2c_cmd_t CMD_ACK  = 6'b010000; // ack after read
	localparam i2c_cmd_t CMD_NACK = 6'b100000; // nack after read

	// one fifo entry, same layout as the cmd word
	typedef struct packed {
		i2c_cmd_t  flags;   // word bits 13:8
		i2c_data_t tx_data; // word bits 7:0
	} i2c_cmd_entry_t;

	// bit engine states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_GEN_STA,
		ST_WR_DATA,
		ST_RD_DATA,
		ST_CHECK_ACK,
		ST_GEN_ACK,
		ST_GEN_STO
	} bit_state_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the i2c master testbench with verilator, run it, then scan the log
rm -f sim.log build.log
verilator --binary --timing -Wno-fatal --top-module tb_i2c_master -f src.f -o tb_sim \
	> build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

// File: src.f
hdl/i2c_pkg.sv
hdl/i2c_apb_regs.sv
hdl/i2c_cmd_fifo.sv
hdl/i2c_bit_shift.sv
hdl/i2c_master_top.sv
tb/tb_i2c_slave.sv
tb/tb_i2c_master.sv

// File: tb/tb_i2c_master.sv
`default_nettype none

module tb_i2c_master import i2c_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [6:0] SLAVE_ADDR  = 7'h50;
	localparam int         IDLE_POLLS  = 20000; // status reads before giving up
	localparam int         READY_WAITS = 16;

	logic      Clk;
	logic      Rst_n;
	apb_addr_t paddr;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_data_t pwdata;
	apb_data_t prdata;
	logic      pready;
	logic      pslverr;
	logic      scl;
	logic      sda_oe;
	logic      sda;
	logic      slave_pull;
	i2c_data_t slave_data;
	integer    seed;
	int        errors;
	int        tests_passed;
	int        tests_failed;
	i2c_data_t model_byte; // slave register as the model sees it

	// open-drain bus where either side may pull low
	assign sda = ~(sda_oe | slave_pull);

	i2c_master_top u_i2c_master_top (
		.Clk       (Clk),
		.Rst_n     (Rst_n),
		.paddr_i   (paddr),
		.psel_i    (psel),
		.penable_i (penable),
		.pwrite_i  (pwrite),
		.pwdata_i  (pwdata),
		.prdata_o  (prdata),
		.pready_o  (pready),
		.pslverr_o (pslverr),
		.scl_o     (scl),
		.sda_oe_o  (sda_oe),
		.sda_i     (sda)
	);

	tb_i2c_slave u_slave (
		.Clk        (Clk),
		.Rst_n      (Rst_n),
		.scl_i      (scl),
		.sda_i      (sda),
		.sda_pull_o (slave_pull),
		.data_o     (slave_data)
	);

	always #4 Clk = ~Clk; // 8 ns period

	task automatic stop_on_timeout(input string what);
		$display("timeout: gave up waiting for %s at %0t ns", what, $time);
		$display("STATUS: FAIL");
		$finish;
	endtask

	// one apb transfer with setup then access
	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
			output apb_data_t rdata, output logic err);
		int waits;
		@(posedge Clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge Clk);
		penable <= 1'b1;
		waits = 0;
		@(negedge Clk);
		while (!pready && (waits < READY_WAITS)) begin
			@(negedge Clk);
			waits++;
		end
		if (!pready) stop_on_timeout("pready");
		rdata = prdata; // sampled mid-cycle when settled
		err   = pslverr;
		@(posedge Clk);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		apb_data_t ignored;
		apb_xfer(1'b1, addr, data, ignored, err);
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	task automatic check_data(input i2c_data_t got, input i2c_data_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_ack(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %b, expected %b (1 = nack)", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input apb_data_t got, input apb_data_t exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// cmd register layout with data low and flags above
	function automatic apb_data_t cmd_word(input i2c_cmd_t flags, input i2c_data_t data);
		return {18'd0, flags, data};
	endfunction

	function automatic logic expect_nack(input i2c_data_t addr_byte);
		return (addr_byte[7:1] != SLAVE_ADDR);
	endfunction

	task automatic queue_cmd(input i2c_cmd_t flags, input i2c_data_t data);
		logic err;
		apb_write(REG_CMD, cmd_word(flags, data), err);
		check_bit(err, 1'b0, "command write error");
	endtask

	// poll status until the busy bit drops
	task automatic wait_idle();
		apb_data_t st;
		logic      err;
		int        polls;
		st    = 32'h1;
		polls = 0;
		while (st[0] && (polls < IDLE_POLLS)) begin
			apb_read(REG_STATUS, st, err);
			polls++;
		end
		if (st[0]) stop_on_timeout("busy to clear");
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		if (errors == errs_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, errors - errs_at_start);
		end
	endtask

	initial begin
		apb_data_t rd;
		logic      err;
		logic      full_seen;
		i2c_data_t d1;
		i2c_data_t d2;
		i2c_data_t bad;
		scl_div_t  div;
		int        mark;
		int        full_cnt;
		int        err_cnt;
		int        i;

		seed         = 32'h797d650c;
		errors       = 0;
		tests_passed = 0;
		tests_failed = 0;
		model_byte   = 8'h00; // slave register reset value
		Clk          = 1'b0;
		Rst_n        = 1'b0;
		paddr        = '0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = '0;
		repeat (10) @(posedge Clk);
		Rst_n <= 1'b1;

		mark = errors;
		apb_read(REG_STATUS, rd, err);
		check_word(rd, 32'h0, "status after reset");
		check_bit(err, 1'b0, "status read error");
		apb_read(REG_CTRL, rd, err);
		check_word(rd, 32'd24, "ctrl after reset");
		@(negedge Clk);
		check_bit(scl, 1'b1, "scl at idle");
		check_bit(sda_oe, 1'b0, "sda pull-low at idle");
		end_test("reset values", mark);

		mark = errors;
		repeat (6) begin
			div = scl_div_t'(4 + $unsigned($random(seed)) % 37); // 4 .. 40
			apb_write(REG_CTRL, apb_data_t'(div), err);
			check_bit(err, 1'b0, "ctrl write error");
			apb_read(REG_CTRL, rd, err);
			check_word(rd, apb_data_t'(div), "ctrl read-back");
		end
		apb_write(REG_STATUS, 32'h5a, err);
		check_bit(err, 1'b1, "status write error");
		apb_write(8'h10, 32'h5a, err);
		check_bit(err, 1'b1, "unmapped write error");
		end_test("ctrl and decode", mark);

		mark = errors;
		repeat (20) begin
			d1 = i2c_data_t'($random(seed));
			d2 = i2c_data_t'($random(seed));
			queue_cmd(CMD_STA | CMD_WR, 8'hA0);
			queue_cmd(CMD_WR, d1);
			queue_cmd(CMD_WR | CMD_STO, d2);
			wait_idle();
			model_byte = d2; // last data byte wins
			apb_read(REG_STATUS, rd, err);
			check_ack(rd[2], expect_nack(8'hA0), "write ack");
			check_data(slave_data, model_byte, "slave register");
		end
		end_test("write transactions", mark);

		mark = errors;
		repeat (4) begin
			d1 = i2c_data_t'($random(seed));
			queue_cmd(CMD_STA | CMD_WR, 8'hA0);
			queue_cmd(CMD_WR | CMD_STO, d1);
			wait_idle();
			model_byte = d1;
			queue_cmd(CMD_STA | CMD_WR, 8'hA1);
			queue_cmd(CMD_RD | CMD_NACK | CMD_STO, 8'h00);
			wait_idle();
			apb_read(REG_RXDATA, rd, err);
			check_data(rd[7:0], model_byte, "received byte");
			apb_read(REG_STATUS, rd, err);
			check_ack(rd[2], expect_nack(8'hA1), "read address ack");
		end
		end_test("read transactions", mark);

		mark = errors;
		repeat (3) begin
			bad = i2c_data_t'($random(seed));
			d1  = i2c_data_t'($random(seed));
			if (bad[7:1] == SLAVE_ADDR) bad[7] = ~bad[7]; // force a miss
			if (d1 == model_byte) d1 = ~d1; // a stored byte would show
			queue_cmd(CMD_STA | CMD_WR, bad);
			queue_cmd(CMD_WR | CMD_STO, d1);
			wait_idle();
			apb_read(REG_STATUS, rd, err);
			check_ack(rd[2], expect_nack(bad), "wrong address ack");
			check_data(slave_data, model_byte, "slave register kept");
		end
		end_test("wrong address", mark);

		mark = errors;
		apb_write(REG_CTRL, 32'd4, err);
		full_cnt = 0;
		err_cnt  = 0;
		for (i = 0; i < 6; i++) begin
			d1 = (i == 0) ? 8'hA0 : i2c_data_t'($random(seed));
			apb_read(REG_STATUS, rd, err);
			full_seen = rd[1];
			apb_write(REG_CMD, cmd_word((i == 0) ? (CMD_STA | CMD_WR) : CMD_WR, d1), err);
			check_bit(err, full_seen, "command error against full flag");
			if (full_seen) full_cnt++;
			if (err) begin
				err_cnt++; // command dropped
			end else if (i > 0) begin
				model_byte = d1;
			end
		end
		check_word(apb_data_t'(full_cnt), 32'd1, "full after one popped and four queued");
		check_word(apb_data_t'(err_cnt), apb_data_t'(full_cnt), "dropped commands");
		wait_idle();
		queue_cmd(CMD_STO, 8'h00); // close the open transfer
		wait_idle();
		check_data(slave_data, model_byte, "slave register after burst");
		apb_read(REG_STATUS, rd, err);
		check_word(rd, 32'h0, "status after burst");
		end_test("fifo full", mark);

		$display("tests passed %0d, failed %0d, mismatches %0d", tests_passed, tests_failed,
			errors);
		if ((tests_failed == 0) && (errors == 0)) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/tb_i2c_slave.sv
`default_nettype none

module tb_i2c_slave import i2c_pkg::*; (
	input  wire       Clk,
	input  wire       Rst_n,
	input  wire       scl_i,
	input  wire       sda_i,      // resolved line level
	output logic      sda_pull_o, // 1 pulls sda low
	output i2c_data_t data_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [6:0] SLAVE_ADDR = 7'h50;

	typedef enum logic [2:0] {
		S_IDLE,
		S_ADDR,
		S_WRITE,
		S_READ,
		S_IGNORE // not addressed, wait for stop
	} slave_state_t;

	slave_state_t state;
	logic         scl_q;       // lines one clock back
	logic         sda_q;
	logic [3:0]   bit_cnt;     // scl rises in this byte, 9th is the ack clock
	i2c_data_t    shift;
	i2c_data_t    data_q;      // the single data register
	logic         master_nack;
	logic         addr_match;
	logic         scl_rise;
	logic         scl_fall;
	logic         start_seen;
	logic         stop_seen;

	// lines oversampled on the system clock
	assign scl_rise   = scl_i & ~scl_q;
	assign scl_fall   = ~scl_i & scl_q;
	assign start_seen = scl_i & scl_q & sda_q & ~sda_i; // sda falls under high scl
	assign stop_seen  = scl_i & scl_q & ~sda_q & sda_i; // sda rises under high scl
	assign addr_match = (shift[7:1] == SLAVE_ADDR);
	assign data_o     = data_q;

	always_ff @(posedge Clk or negedge Rst_n) begin
		if (!Rst_n) begin
			state       <= S_IDLE;
			scl_q       <= 1'b1;
			sda_q       <= 1'b1;
			bit_cnt     <= '0;
			shift       <= '0;
			data_q      <= '0;
			master_nack <= 1'b0;
			sda_pull_o  <= 1'b0;
		end else begin
			scl_q <= scl_i;
			sda_q <= sda_i;
			if (start_seen) begin
				state      <= S_ADDR;
				bit_cnt    <= '0;
				sda_pull_o <= 1'b0;
			end else if (stop_seen) begin
				state      <= S_IDLE;
				sda_pull_o <= 1'b0;
			end else if (scl_rise && (state != S_IDLE) && (state != S_IGNORE)) begin
				if ((state != S_READ) && (bit_cnt < 4'd8)) shift <= {shift[6:0], sda_i};
				if ((state == S_READ) && (bit_cnt == 4'd8)) master_nack <= sda_i; // high = nack
				bit_cnt <= bit_cnt + 4'd1;
			end else if (scl_fall) begin
				case (state)
					S_ADDR: begin
						if (bit_cnt == 4'd8) begin
							sda_pull_o <= addr_match; // ack only our address
						end else if (bit_cnt == 4'd9) begin
							bit_cnt <= '0;
							if (!addr_match) begin
								state <= S_IGNORE;
							end else if (shift[0]) begin
								state      <= S_READ;
								sda_pull_o <= ~data_q[7]; // msb right after the ack
							end else begin
								state      <= S_WRITE;
								sda_pull_o <= 1'b0;
							end
						end
					end
					S_WRITE: begin
						if (bit_cnt == 4'd8) begin
							data_q     <= shift; // byte complete
							sda_pull_o <= 1'b1;
						end else if (bit_cnt == 4'd9) begin
							sda_pull_o <= 1'b0;
							bit_cnt    <= '0;
						end
					end
					S_READ: begin
						if (bit_cnt == 4'd9) begin
							bit_cnt <= '0;
							if (master_nack) begin
								state      <= S_IGNORE;
								sda_pull_o <= 1'b0;
							end else begin
								sda_pull_o <= ~data_q[7]; // same register again
							end
						end else if (bit_cnt == 4'd8) begin
							sda_pull_o <= 1'b0; // master owns the ack bit
						end else if (bit_cnt != 4'd0) begin
							sda_pull_o <= ~data_q[3'd7 - bit_cnt[2:0]];
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire
